/* common/xadd_cfg.svh */
// the modulus must equal 2**XADD_FP_W - 1 because reduction folds the high bits back in
`ifndef XADD_CFG_SVH
`define XADD_CFG_SVH

// width of one GF(p) value
`define XADD_FP_W 13

// field prime, 3 mod 4 so i*i = -1 builds GF(p^2)
`define XADD_P_MODULUS 8191

// butterfly 1 + cross 2 + butterfly 1 + square 2 + scale 2
`define XADD_LATENCY 8

`endif

/* common/xadd_pkg.sv */
// field helpers expect operands already reduced below p and a Mersenne modulus
`include "xadd_cfg.svh"

package xadd_pkg;

  localparam int FP_W = `XADD_FP_W;

  // one GF(p) element
  typedef logic [FP_W-1:0] fp_t;
  // raw product of two elements
  typedef logic [2*FP_W-1:0] fp_prod_t;
  // sum of two products, one bit of headroom
  typedef logic [2*FP_W:0] fp_wide_t;

  localparam fp_t P_MOD = fp_t'(`XADD_P_MODULUS);

  // element of GF(p^2) as re + i*im
  typedef struct packed {
    fp_t re;
    fp_t im;
  } fp2_t;

  // one xADD job
  typedef struct packed {
    fp2_t xp;
    fp2_t zp;
    fp2_t xq;
    fp2_t zq;
    fp2_t xpq;
    fp2_t zpq;
  } xadd_in_t;

  // difference point, carried to the scaling stage
  typedef struct packed {
    fp2_t xpq;
    fp2_t zpq;
  } pq_pair_t;

  // new Q in projective x-only form
  typedef struct packed {
    fp2_t xq;
    fp2_t zq;
  } xadd_out_t;

  function automatic fp_t fp_add(fp_t a, fp_t b);
    logic [FP_W:0] s;
    s = {1'b0, a} + {1'b0, b};
    if (s >= {1'b0, P_MOD}) begin
      s = s - {1'b0, P_MOD};
    end
    return s[FP_W-1:0];
  endfunction

  function automatic fp_t fp_sub(fp_t a, fp_t b);
    logic [FP_W:0] d;
    // a + p - b stays positive and below 2p
    d = {1'b0, a} + {1'b0, P_MOD} - {1'b0, b};
    if (d >= {1'b0, P_MOD}) begin
      d = d - {1'b0, P_MOD};
    end
    return d[FP_W-1:0];
  endfunction

  // 2**FP_W == 1 mod p, so the upper bits fold onto the lower ones
  function automatic fp_t fp_mod_reduce(fp_wide_t x);
    logic [FP_W+1:0] s1;
    logic [FP_W:0] s2;
    s1 = {1'b0, x[2*FP_W:FP_W]} + {2'b00, x[FP_W-1:0]};
    // second fold leaves at most p + 3
    s2 = {1'b0, s1[FP_W-1:0]} + {{(FP_W-1){1'b0}}, s1[FP_W+1:FP_W]};
    if (s2 >= {1'b0, P_MOD}) begin
      s2 = s2 - {1'b0, P_MOD};
    end
    return s2[FP_W-1:0];
  endfunction

endpackage

/* dv/xadd_assert.sv */
// latency check starts XADD_LATENCY cycles after each reset release
`include "xadd_cfg.svh"

module xadd_assert (
  input logic                clk,
  input logic                rst,
  input logic                in_valid,
  input logic                out_valid,
  input xadd_pkg::xadd_out_t out_data
);

  import xadd_pkg::*;

  localparam int LAT = `XADD_LATENCY;

  // cycles since reset, stops at LAT
  int since_rst;

  always @(posedge clk or posedge rst) begin
    if (rst) begin
      since_rst <= 0;
    end else if (since_rst < LAT) begin
      since_rst <= since_rst + 1;
    end
  end

  latency_a: assert property (@(posedge clk) disable iff (rst)
    (since_rst >= LAT) |-> (out_valid == $past(in_valid, LAT)))
    else $error("out_valid does not follow in_valid by %0d cycles", LAT);

  quiet_a: assert property (@(posedge clk) disable iff (rst)
    (since_rst < LAT) |-> !out_valid)
    else $error("out_valid high before a full pipeline has passed since reset");

  range_a: assert property (@(posedge clk) disable iff (rst)
    out_valid |-> (out_data.xq.re < P_MOD && out_data.xq.im < P_MOD
                   && out_data.zq.re < P_MOD && out_data.zq.im < P_MOD))
    else $error("result part not reduced below p");

endmodule

bind xadd_top xadd_assert u_assert (
  .clk       (clk),
  .rst       (rst),
  .in_valid  (in_valid),
  .out_valid (out_valid),
  .out_data  (out_data)
);

/* dv/xadd_checker.sv */
// expects one reference push per accepted item; results must leave in input order
`include "xadd_cfg.svh"

module xadd_checker (
  input  logic                clk,
  input  logic                rst,
  input  int                  cycle,
  input  logic                exp_valid,
  input  xadd_pkg::xadd_out_t exp_data,
  input  logic                out_valid,
  input  xadd_pkg::xadd_out_t out_data,
  output int                  checked,
  output int                  errors,
  output int                  pending
);

  import xadd_pkg::*;

  localparam int LAT = `XADD_LATENCY;

  // expected result and the cycle it is due at the output
  typedef struct packed {
    xadd_out_t data;
    int        due;
  } expect_t;

  expect_t exp_q[$];

  always @(posedge clk) begin
    expect_t head;
    if (rst) begin
      // in-flight items are lost on reset
      exp_q.delete();
    end else begin
      if (out_valid) begin
        if (exp_q.size() == 0) begin
          $display("ERROR: time %0t output with no expected result, out_data=%h",
                   $time, out_data);
          errors = errors + 1;
        end else begin
          head = exp_q.pop_front();
          checked = checked + 1;
          if (out_data.xq !== head.data.xq) begin
            $display("CHECK FAILED time=%0t signal=out_data.xq expected=%h actual=%h",
                     $time, head.data.xq, out_data.xq);
            errors = errors + 1;
          end
          if (out_data.zq !== head.data.zq) begin
            $display("CHECK FAILED time=%0t signal=out_data.zq expected=%h actual=%h",
                     $time, head.data.zq, out_data.zq);
            errors = errors + 1;
          end
          if (cycle != head.due) begin
            $display("ERROR: time %0t result came out at cycle %0d but was due at cycle %0d",
                     $time, cycle, head.due);
            errors = errors + 1;
          end
        end
      end
      if (exp_valid) begin
        exp_q.push_back('{data: exp_data, due: cycle + LAT});
      end
    end
    pending = exp_q.size();
  end

endmodule

/* dv/xadd_tb.sv */
// random stimulus from a fixed LFSR seed; timing checks assume a reset-clean pipeline
`include "xadd_cfg.svh"

module xadd_tb;

  import xadd_pkg::*;

  localparam int     LAT     = `XADD_LATENCY;
  localparam longint P       = longint'(`XADD_P_MODULUS);
  localparam int     N_RAND  = 64;
  localparam int     N_TESTS = 5;
  localparam int     MAX_GAP = 3;
  localparam int     N_ITEMS = 2 + 2 * N_RAND + 13;
  // reset, idle, worst-case gaps and drain time of every test
  localparam int MAX_CYCLES = 4 + 20 + N_ITEMS * (1 + MAX_GAP) + (LAT + 2)
                              + (LAT + 4) * N_TESTS + 100;

  logic      clk;
  logic      rst;
  logic      in_valid;
  xadd_in_t  in_data;
  logic      out_valid;
  xadd_out_t out_data;
  logic      exp_valid;
  xadd_out_t exp_data;

  int          cycle;
  int          chk_count;
  int          err_count;
  int          pending;
  int          stray_errors;
  int          base_chk;
  int          base_err;
  int          tests_run;
  logic [15:0] lfsr;

  xadd_top i_dut (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

  xadd_checker u_chk (
    .clk       (clk),
    .rst       (rst),
    .cycle     (cycle),
    .exp_valid (exp_valid),
    .exp_data  (exp_data),
    .out_valid (out_valid),
    .out_data  (out_data),
    .checked   (chk_count),
    .errors    (err_count),
    .pending   (pending)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= MAX_CYCLES) begin
      $display("ERROR: run did not finish within %0d cycles", MAX_CYCLES);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_step(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic int take_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return int'(r);
  endfunction

  function automatic fp2_t rand_fp2();
    fp2_t v;
    v.re = fp_t'(longint'(take_bits(`XADD_FP_W)) % P);
    v.im = fp_t'(longint'(take_bits(`XADD_FP_W)) % P);
    return v;
  endfunction

  function automatic xadd_in_t rand_item();
    xadd_in_t it;
    it.xp  = rand_fp2();
    it.zp  = rand_fp2();
    it.xq  = rand_fp2();
    it.zq  = rand_fp2();
    it.xpq = rand_fp2();
    it.zpq = rand_fp2();
    return it;
  endfunction

  function automatic fp2_t sum_fp2(fp2_t a, fp2_t b);
    fp2_t r;
    r.re = fp_t'((longint'(a.re) + longint'(b.re)) % P);
    r.im = fp_t'((longint'(a.im) + longint'(b.im)) % P);
    return r;
  endfunction

  function automatic fp2_t diff_fp2(fp2_t a, fp2_t b);
    fp2_t r;
    r.re = fp_t'((longint'(a.re) - longint'(b.re) + P) % P);
    r.im = fp_t'((longint'(a.im) - longint'(b.im) + P) % P);
    return r;
  endfunction

  // (a + bi)(c + di) with i*i = -1
  function automatic fp2_t prod_fp2(fp2_t a, fp2_t b);
    longint re;
    longint im;
    fp2_t   r;
    re = longint'(a.re) * longint'(b.re) - longint'(a.im) * longint'(b.im);
    im = longint'(a.re) * longint'(b.im) + longint'(a.im) * longint'(b.re);
    r.re = fp_t'(((re % P) + P) % P);
    r.im = fp_t'(im % P);
    return r;
  endfunction

  // X = zPQ (t2 + t3)^2, Z = xPQ (t2 - t3)^2
  function automatic xadd_out_t xadd_ref(xadd_in_t it);
    fp2_t      t2;
    fp2_t      t3;
    xadd_out_t r;
    t2 = prod_fp2(diff_fp2(it.xq, it.zq), sum_fp2(it.xp, it.zp));
    t3 = prod_fp2(sum_fp2(it.xq, it.zq), diff_fp2(it.xp, it.zp));
    r.xq = prod_fp2(it.zpq, prod_fp2(sum_fp2(t2, t3), sum_fp2(t2, t3)));
    r.zq = prod_fp2(it.xpq, prod_fp2(diff_fp2(t2, t3), diff_fp2(t2, t3)));
    return r;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  task automatic idle(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic send_item(input xadd_in_t it);
    in_valid  = 1'b1;
    in_data   = it;
    exp_valid = 1'b1;
    exp_data  = xadd_ref(it);
    next_cycle();
    in_valid  = 1'b0;
    exp_valid = 1'b0;
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    idle(2);
    rst = 1'b0;
  endtask

  // let the last results drain, then report the test
  task automatic close_test(input string name);
    int waited;
    waited = 0;
    while (pending > 0 && waited < LAT + 4) begin
      next_cycle();
      waited++;
    end
    if (pending > 0) begin
      $display("ERROR: test %s ended with %0d results still pending", name, pending);
      stray_errors = stray_errors + pending;
    end
    $display("test %s: %0d results checked, %0d errors", name, chk_count - base_chk,
             err_count + stray_errors - base_err);
    base_chk = chk_count;
    base_err = err_count + stray_errors;
    tests_run++;
  endtask

  initial begin
    clk       = 1'b0;
    rst       = 1'b1;
    in_valid  = 1'b0;
    in_data   = '0;
    exp_valid = 1'b0;
    exp_data  = '0;
    lfsr      = 16'd56735;
    apply_reset();

    // nothing may come out of an empty pipeline
    idle(20);
    close_test("idle");

    send_item('0);
    idle(LAT);
    send_item({12{fp_t'(P - 1)}});
    close_test("corner");

    for (int i = 0; i < N_RAND; i++) begin
      send_item(rand_item());
    end
    close_test("burst");

    for (int i = 0; i < N_RAND; i++) begin
      send_item(rand_item());
      idle(take_bits(2));
    end
    close_test("gaps");

    // these five are still in flight when rst hits
    for (int i = 0; i < 5; i++) begin
      send_item(rand_item());
    end
    apply_reset();
    idle(LAT + 2);
    for (int i = 0; i < 8; i++) begin
      send_item(rand_item());
    end
    close_test("reset");

    $display("summary: %0d tests, %0d results checked, %0d errors", tests_run, chk_count,
             err_count + stray_errors);
    if (err_count + stray_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* fp2/fp2_butterfly_stage.sv */
// inputs must be reduced below p; holds its outputs when in_valid is low
module fp2_butterfly_stage (
  input  logic           clk,
  input  logic           rst,
  input  logic           in_valid,
  input  xadd_pkg::fp2_t a,
  input  xadd_pkg::fp2_t b,
  output logic           out_valid,
  output xadd_pkg::fp2_t sum,
  output xadd_pkg::fp2_t diff
);

  import xadd_pkg::*;

  fp2_t sum_d;
  fp2_t diff_d;

  // parts are independent in GF(p^2) addition
  always_comb begin
    sum_d.re  = fp_add(a.re, b.re);
    sum_d.im  = fp_add(a.im, b.im);
    diff_d.re = fp_sub(a.re, b.re);
    diff_d.im = fp_sub(a.im, b.im);
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  // data only loads on a live item
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sum  <= '0;
      diff <= '0;
    end else if (in_valid) begin
      sum  <= sum_d;
      diff <= diff_d;
    end
  end

endmodule

/* fp2/fp2_mul_pair_stage.sv */
// two independent GF(p^2) products with fixed two-cycle latency and no stall
module fp2_mul_pair_stage (
  input  logic           clk,
  input  logic           rst,
  input  logic           in_valid,
  input  xadd_pkg::fp2_t a0,
  input  xadd_pkg::fp2_t b0,
  input  xadd_pkg::fp2_t a1,
  input  xadd_pkg::fp2_t b1,
  output logic           out_valid,
  output xadd_pkg::fp2_t p0,
  output xadd_pkg::fp2_t p1
);

  import xadd_pkg::*;

  // integer cross terms of (a + bi)(c + di)
  typedef struct packed {
    fp_prod_t ac;
    fp_prod_t bd;
    fp_prod_t ad;
    fp_prod_t bc;
  } partial_t;

  localparam fp_wide_t P_SQ = fp_wide_t'(P_MOD) * fp_wide_t'(P_MOD);

  partial_t pp0_q;
  partial_t pp1_q;
  logic     mid_valid;

  function automatic partial_t fp2_partials(fp2_t x, fp2_t y);
    partial_t pp;
    pp.ac = fp_prod_t'(x.re) * fp_prod_t'(y.re);
    pp.bd = fp_prod_t'(x.im) * fp_prod_t'(y.im);
    pp.ad = fp_prod_t'(x.re) * fp_prod_t'(y.im);
    pp.bc = fp_prod_t'(x.im) * fp_prod_t'(y.re);
    return pp;
  endfunction

  // real part ac - bd, imaginary part ad + bc
  function automatic fp2_t fp2_combine(partial_t pp);
    fp_wide_t re_w;
    fp_wide_t im_w;
    fp2_t     r;
    // p^2 offset keeps ac - bd non-negative and is 0 mod p
    re_w = fp_wide_t'(pp.ac) + P_SQ - fp_wide_t'(pp.bd);
    im_w = fp_wide_t'(pp.ad) + fp_wide_t'(pp.bc);
    r.re = fp_mod_reduce(re_w);
    r.im = fp_mod_reduce(im_w);
    return r;
  endfunction

  // valid pipe
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      mid_valid <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      mid_valid <= in_valid;
      out_valid <= mid_valid;
    end
  end

  // first cycle, raw multiplies
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pp0_q <= '0;
      pp1_q <= '0;
    end else if (in_valid) begin
      pp0_q <= fp2_partials(a0, b0);
      pp1_q <= fp2_partials(a1, b1);
    end
  end

  // second cycle, combine and fold back below p
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      p0 <= '0;
      p1 <= '0;
    end else if (mid_valid) begin
      p0 <= fp2_combine(pp0_q);
      p1 <= fp2_combine(pp1_q);
    end
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# builds the xadd testbench with Verilator and runs it

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "cannot enter project directory"
  exit 1
fi

verilator --binary --assert --top-module xadd_tb -f verilog.f --Mdir obj_dir -o xadd_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/xadd_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***'; then
  exit 0
fi
exit 1

/* src/pq_delay_line.sv */
// shifts every cycle with no enable, so DEPTH must match the pipeline cycles it spans
module pq_delay_line #(
  parameter int DEPTH = 6
) (
  input  logic               clk,
  input  logic               rst,
  input  xadd_pkg::pq_pair_t in_pq,
  output xadd_pkg::pq_pair_t out_pq
);

  import xadd_pkg::*;

  pq_pair_t taps [DEPTH];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        taps[i] <= '0;
      end
    end else begin
      taps[0] <= in_pq;
      // older entries move one slot down
      for (int i = 1; i < DEPTH; i++) begin
        taps[i] <= taps[i-1];
      end
    end
  end

  assign out_pq = taps[DEPTH-1];

endmodule

/* src/xadd_top.sv */
// one item per cycle, result exactly XADD_LATENCY cycles later, no back-pressure
`include "xadd_cfg.svh"

module xadd_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_valid,
  input  xadd_pkg::xadd_in_t  in_data,
  output logic                out_valid,
  output xadd_pkg::xadd_out_t out_data
);

  import xadd_pkg::*;

  // stage 1, P and Q butterflies
  logic s1_valid;
  fp2_t p_sum;
  fp2_t p_diff;
  fp2_t q_sum;
  fp2_t q_diff;

  // stage 2, cross products t2 and t3
  logic cross_valid;
  fp2_t cross_t2;
  fp2_t cross_t3;

  // stage 3
  logic mid_valid;
  fp2_t mid_sum;
  fp2_t mid_diff;

  // stage 4
  logic sq_valid;
  fp2_t sq_sum;
  fp2_t sq_diff;

  pq_pair_t pq_in;
  pq_pair_t pq_dly;
  fp2_t     xq_new;
  fp2_t     zq_new;

  assign pq_in = '{xpq: in_data.xpq, zpq: in_data.zpq};

  fp2_butterfly_stage u_bfly_p (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .a         (in_data.xp),
    .b         (in_data.zp),
    .out_valid (s1_valid),
    .sum       (p_sum),
    .diff      (p_diff)
  );

  // runs in lockstep with u_bfly_p
  fp2_butterfly_stage u_bfly_q (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .a         (in_data.xq),
    .b         (in_data.zq),
    .out_valid (),
    .sum       (q_sum),
    .diff      (q_diff)
  );

  fp2_mul_pair_stage u_cross (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (s1_valid),
    .a0        (q_diff),
    .b0        (p_sum),
    .a1        (q_sum),
    .b1        (p_diff),
    .out_valid (cross_valid),
    .p0        (cross_t2),
    .p1        (cross_t3)
  );

  fp2_butterfly_stage u_bfly_mid (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (cross_valid),
    .a         (cross_t2),
    .b         (cross_t3),
    .out_valid (mid_valid),
    .sum       (mid_sum),
    .diff      (mid_diff)
  );

  // squaring, each lane multiplies a value by itself
  fp2_mul_pair_stage u_square (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (mid_valid),
    .a0        (mid_sum),
    .b0        (mid_sum),
    .a1        (mid_diff),
    .b1        (mid_diff),
    .out_valid (sq_valid),
    .p0        (sq_sum),
    .p1        (sq_diff)
  );

  // everything ahead of the scaling stage
  pq_delay_line #(
    .DEPTH (`XADD_LATENCY - 2)
  ) u_pq_dly (
    .clk    (clk),
    .rst    (rst),
    .in_pq  (pq_in),
    .out_pq (pq_dly)
  );

  fp2_mul_pair_stage u_scale (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (sq_valid),
    .a0        (pq_dly.zpq),
    .b0        (sq_sum),
    .a1        (pq_dly.xpq),
    .b1        (sq_diff),
    .out_valid (out_valid),
    .p0        (xq_new),
    .p1        (zq_new)
  );

  assign out_data = '{xq: xq_new, zq: zq_new};

endmodule

/* verilog.f */
+incdir+common
common/xadd_pkg.sv
fp2/fp2_butterfly_stage.sv
fp2/fp2_mul_pair_stage.sv
src/pq_delay_line.sv
src/xadd_top.sv
dv/xadd_assert.sv
dv/xadd_checker.sv
dv/xadd_tb.sv
